// ==== filelist.f ====
ifetch_pkg.sv
ifetch_req_if.sv
ifetch_rsp_if.sv
ifetch_req_former.sv
ifetch_bus_fsm.sv
ifetch_inst_out.sv
ifetch_top.sv
tb_clkgen.sv
tb_ifetch_sva.sv
tb_ifetch.sv

// ==== ifetch_bus_fsm.sv ====
//----------------------------------------------------------------------------
// fetch bus state machine with two outstanding transactions, abort tracking
// and a per transaction attribute queue
//----------------------------------------------------------------------------

module ifetch_bus_fsm
  import ifetch_pkg::*;
(
  input  logic              ifetch_cpuclk,
  input  logic              cpurst_b,
  ifetch_req_if.fsm         req,
  ifetch_rsp_if.fsm         rsp,
  input  logic              bus_grant,
  input  logic              bus_trans_cmplt,
  input  logic              bus_acc_err,
  input  logic [data_w-1:0] bus_rdata,
  input  logic              fetch_abort,
  output logic              bus_req,
  output logic [addr_w-1:0] bus_addr,
  output logic [prot_w-1:0] bus_prot,
  output logic              bus_acc_deny
);

  bus_st_t    cur_st;
  bus_st_t    nxt_st;
  abt_st_t    abt_cur_st;
  abt_st_t    abt_nxt_st;
  logic       st_data_wait;
  logic       cmplt_raw;
  logic       abt_trig;
  logic [1:0] live_cnt;
  logic [1:0] discard_cnt;
  xact_attr_t attr_q [2];
  xact_attr_t attr_in;
  xact_attr_t attr_head;
  logic       attr_push;
  logic       attr_wr_ptr;
  logic       attr_rd_ptr;

  //--------------------------------------------------------------------------
  // bus state machine
  //--------------------------------------------------------------------------
  always_ff @(posedge ifetch_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_st <= st_idle;
    else
      cur_st <= nxt_st;
  end

  always_comb
  begin
    case (cur_st)
      st_idle:
        if (req.req_vld)
          nxt_st = bus_grant ? st_wfd1 : st_wfg1;
        else
          nxt_st = st_idle;
      st_wfg1:
        nxt_st = bus_grant ? st_wfd1 : st_wfg1;
      st_wfd1:
        if (bus_trans_cmplt)
          if (req.req_vld)
            nxt_st = bus_grant ? st_wfd1 : st_wfg1;
          else
            nxt_st = st_idle;
        else if (req.req_vld)
          nxt_st = bus_grant ? st_wfd1_wfd2 : st_wfd1_wfg2;
        else
          nxt_st = st_wfd1;
      st_wfd1_wfg2:
        if (bus_trans_cmplt)
          nxt_st = bus_grant ? st_wfd1 : st_wfg1;
        else
          nxt_st = bus_grant ? st_wfd1_wfd2 : st_wfd1_wfg2;
      st_wfd1_wfd2:
        nxt_st = bus_trans_cmplt ? st_wfd1 : st_wfd1_wfd2;
      default:
        nxt_st = st_idle;
    endcase
  end

  assign st_data_wait = (cur_st == st_wfd1) | (cur_st == st_wfd1_wfg2)
                      | (cur_st == st_wfd1_wfd2);
  assign cmplt_raw    = st_data_wait & bus_trans_cmplt;

  // a request waiting for grant stays on the bus until it is granted,
  // no new request while two are already in flight
  assign bus_req = ((cur_st == st_idle) & req.req_vld)
                 | (cur_st == st_wfg1)
                 | ((cur_st == st_wfd1) & req.req_vld)
                 | (cur_st == st_wfd1_wfg2);

  //--------------------------------------------------------------------------
  // abort tracker
  //--------------------------------------------------------------------------
  // every transaction alive at the abort is discarded, also one that is
  // still pending and gets granted later
  always_comb
  begin
    case (cur_st)
      st_wfg1, st_wfd1:           live_cnt = 2'd1;
      st_wfd1_wfg2, st_wfd1_wfd2: live_cnt = 2'd2;
      default:                    live_cnt = 2'd0;
    endcase
  end

  // a completion in the abort cycle itself is still delivered
  assign discard_cnt = live_cnt - {1'b0, cmplt_raw};
  assign abt_trig    = fetch_abort & (cur_st != st_idle);

  always_ff @(posedge ifetch_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      abt_cur_st <= abt_idle;
    else
      abt_cur_st <= abt_nxt_st;
  end

  always_comb
  begin
    if (abt_trig)
      case (discard_cnt)
        2'd1:    abt_nxt_st = abt_vld1;
        2'd2:    abt_nxt_st = abt_vld2;
        default: abt_nxt_st = abt_idle;
      endcase
    else
      case (abt_cur_st)
        abt_vld1: abt_nxt_st = cmplt_raw ? abt_idle : abt_vld1;
        abt_vld2: abt_nxt_st = cmplt_raw ? abt_vld1 : abt_vld2;
        default:  abt_nxt_st = abt_idle;
      endcase
  end

  //--------------------------------------------------------------------------
  // attribute queue, one entry per granted transaction
  //--------------------------------------------------------------------------
  assign attr_push       = bus_req & bus_grant;
  assign attr_in.deny    = req.req_deny;
  assign attr_in.unalign = req.req_addr[1];

  always_ff @(posedge ifetch_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      attr_wr_ptr <= 1'b0;
      attr_rd_ptr <= 1'b0;
    end
    else
    begin
      if (attr_push)
        attr_wr_ptr <= ~attr_wr_ptr;
      // aborted completions pop too, to stay in step with the bus
      if (cmplt_raw)
        attr_rd_ptr <= ~attr_rd_ptr;
    end
  end

  always_ff @(posedge ifetch_cpuclk)
  begin
    if (attr_push)
      attr_q[attr_wr_ptr] <= attr_in;
  end

  assign attr_head = attr_q[attr_rd_ptr];

  //--------------------------------------------------------------------------
  // outputs
  //--------------------------------------------------------------------------
  assign bus_addr     = {req.req_addr[addr_w-1:2], 2'b00};
  assign bus_prot     = req.req_prot;
  assign bus_acc_deny = req.req_deny;

  assign rsp.rsp_cmplt   = cmplt_raw & (abt_cur_st == abt_idle);
  assign rsp.rsp_data    = bus_rdata;
  assign rsp.rsp_err     = bus_acc_err | attr_head.deny;
  assign rsp.rsp_unalign = attr_head.unalign;
  assign rsp.bus_idle    = (cur_st == st_idle);

endmodule

// ==== ifetch_inst_out.sv ====
//----------------------------------------------------------------------------
// instruction output stage and idle acknowledges
//----------------------------------------------------------------------------

module ifetch_inst_out
  import ifetch_pkg::*;
(
  ifetch_rsp_if.out         rsp,
  input  logic              dbgon,
  input  logic              lockup_mask,
  input  logic              lpmd_req,
  input  logic              srst_req,
  input  logic              lockup_req,
  output logic              inst_vld,
  output logic [data_w-1:0] inst,
  output logic              inst_acc_err,
  output logic              inst_unalign,
  output logic              fetch_idle,
  output logic              lpmd_ack,
  output logic              srst_ack,
  output logic              lockup_ack
);

  logic inst_blocked;

  //--------------------------------------------------------------------------
  // instruction buffer side
  //--------------------------------------------------------------------------
  // in debug mode or lockup nothing new enters the buffer
  assign inst_blocked = dbgon | lockup_mask;

  // same cycle as the bus completion, no register in between
  assign inst_vld     = rsp.rsp_cmplt & ~inst_blocked;
  assign inst         = rsp.rsp_data;
  assign inst_acc_err = rsp.rsp_err;
  // upper halfword holds the instruction
  assign inst_unalign = rsp.rsp_unalign;

  //--------------------------------------------------------------------------
  // idle handshakes
  //--------------------------------------------------------------------------
  assign fetch_idle = rsp.bus_idle;

  // only acknowledge once the bus is quiet
  assign lpmd_ack   = lpmd_req & rsp.bus_idle;
  assign srst_ack   = srst_req & rsp.bus_idle;
  assign lockup_ack = lockup_req & rsp.bus_idle;

endmodule

// ==== ifetch_pkg.sv ====
//----------------------------------------------------------------------------
// instruction fetch bus interface: shared widths, encodings and types
//----------------------------------------------------------------------------

package ifetch_pkg;

  //--------------------------------------------------------------------------
  // widths
  //--------------------------------------------------------------------------
  localparam int addr_w = 32;
  localparam int data_w = 32;
  // system map flags
  localparam int flg_w  = 5;
  // bus protection field
  localparam int prot_w = 4;

  //--------------------------------------------------------------------------
  // system map flag positions
  //--------------------------------------------------------------------------
  localparam int flg_ca_bit  = 3;
  localparam int flg_buf_bit = 2;

  // instruction fetches are always a full word on the bus
  localparam logic [1:0] bus_size_word = 2'b10;

  //--------------------------------------------------------------------------
  // bus state machine
  //--------------------------------------------------------------------------
  // wfg = waiting for grant, wfd = waiting for data
  // bit 0 of st_idle is the only state with bit 0 set alone, keep it so
  typedef enum logic [2:0] {
    st_idle      = 3'b001,
    st_wfg1      = 3'b010,
    st_wfd1      = 3'b011,
    st_wfd1_wfg2 = 3'b000,
    st_wfd1_wfd2 = 3'b110
  } bus_st_t;

  //--------------------------------------------------------------------------
  // abort tracker
  //--------------------------------------------------------------------------
  // number of completions still to be discarded
  typedef enum logic [1:0] {
    abt_idle = 2'b00,
    abt_vld1 = 2'b10,
    abt_vld2 = 2'b11
  } abt_st_t;

  //--------------------------------------------------------------------------
  // per transaction attributes
  //--------------------------------------------------------------------------
  // captured at grant, returned with the matching completion
  typedef struct packed {
    logic deny;
    logic unalign;
  } xact_attr_t;

endpackage

// ==== ifetch_req_former.sv ====
//----------------------------------------------------------------------------
// fetch request former: bus address, protection and deny flag
//----------------------------------------------------------------------------

module ifetch_req_former
  import ifetch_pkg::*;
(
  input  logic              fetch_req_vld,
  input  logic [addr_w-1:0] fetch_addr,
  input  logic [flg_w-1:0]  sysmap_flg,
  input  logic              mach_mode,
  input  logic              pmp_deny,
  output logic [addr_w-1:0] sysmap_pa,
  ifetch_req_if.former      req
);

  logic              flg_ca;
  logic              flg_buf;
  logic [prot_w-1:0] prot;

  //--------------------------------------------------------------------------
  // protection
  //--------------------------------------------------------------------------
  // system map answers for the address presented this cycle
  assign flg_ca  = sysmap_flg[flg_ca_bit];
  assign flg_buf = sysmap_flg[flg_buf_bit];

  // {cacheable, bufferable, privileged, data}
  // instruction fetch, so the data bit stays low
  assign prot = {flg_ca, flg_buf, mach_mode, 1'b0};

  //--------------------------------------------------------------------------
  // request
  //--------------------------------------------------------------------------
  assign req.req_vld  = fetch_req_vld;
  // full address here, alignment happens at the bus
  assign req.req_addr = fetch_addr;
  assign req.req_prot = prot;
  // denied fetches still travel, the error is returned at completion
  assign req.req_deny = pmp_deny;

  // physical address lookup in the system map
  assign sysmap_pa = fetch_addr;

endmodule

// ==== ifetch_req_if.sv ====
//----------------------------------------------------------------------------
// fetch request from the request former to the bus state machine
//----------------------------------------------------------------------------

interface ifetch_req_if
  import ifetch_pkg::*;
();

  // request held by the fetch side until granted
  logic              req_vld;
  logic [addr_w-1:0] req_addr;
  logic [prot_w-1:0] req_prot;
  // pmp denied, still goes out so the bus can flag it
  logic              req_deny;

  modport former (
    output req_vld,
    output req_addr,
    output req_prot,
    output req_deny
  );

  // grant comes straight from the bus, nothing flows back here
  modport fsm (
    input  req_vld,
    input  req_addr,
    input  req_prot,
    input  req_deny
  );

endinterface

// ==== ifetch_rsp_if.sv ====
//----------------------------------------------------------------------------
// accepted bus completions from the bus state machine to the output stage
//----------------------------------------------------------------------------

interface ifetch_rsp_if
  import ifetch_pkg::*;
();

  // one cycle strobe, aborted completions never show up here
  logic              rsp_cmplt;
  logic [data_w-1:0] rsp_data;
  logic              rsp_err;
  logic              rsp_unalign;
  // nothing outstanding and nothing pending
  logic              bus_idle;

  modport fsm (
    output rsp_cmplt,
    output rsp_data,
    output rsp_err,
    output rsp_unalign,
    output bus_idle
  );

  modport out (
    input  rsp_cmplt,
    input  rsp_data,
    input  rsp_err,
    input  rsp_unalign,
    input  bus_idle
  );

endinterface

// ==== ifetch_top.sv ====
//----------------------------------------------------------------------------
// instruction fetch bus interface, top level
//----------------------------------------------------------------------------

module ifetch_top
  import ifetch_pkg::*;
(
  input  logic              ifetch_cpuclk,
  input  logic              cpurst_b,
  // program counter side
  input  logic              fetch_req_vld,
  input  logic [addr_w-1:0] fetch_addr,
  input  logic              fetch_abort,
  output logic              fetch_grant,
  // system map and pmp
  input  logic [flg_w-1:0]  sysmap_flg,
  input  logic              mach_mode,
  input  logic              pmp_deny,
  output logic [addr_w-1:0] sysmap_pa,
  // bus
  output logic              bus_req,
  output logic [addr_w-1:0] bus_addr,
  output logic [prot_w-1:0] bus_prot,
  output logic [1:0]        bus_size,
  output logic              bus_acc_deny,
  input  logic              bus_grant,
  input  logic              bus_trans_cmplt,
  input  logic              bus_acc_err,
  input  logic [data_w-1:0] bus_rdata,
  // instruction buffer
  input  logic              dbgon,
  input  logic              lockup_mask,
  output logic              inst_vld,
  output logic [data_w-1:0] inst,
  output logic              inst_acc_err,
  output logic              inst_unalign,
  // idle handshakes
  output logic              fetch_idle,
  input  logic              lpmd_req,
  output logic              lpmd_ack,
  input  logic              srst_req,
  output logic              srst_ack,
  input  logic              lockup_req,
  output logic              lockup_ack
);

  ifetch_req_if req_if ();
  ifetch_rsp_if rsp_if ();

  // the fetch side sees the bus grant directly
  assign fetch_grant = bus_grant;
  assign bus_size    = bus_size_word;

  ifetch_req_former x_req_former (
    .fetch_req_vld (fetch_req_vld),
    .fetch_addr    (fetch_addr),
    .sysmap_flg    (sysmap_flg),
    .mach_mode     (mach_mode),
    .pmp_deny      (pmp_deny),
    .sysmap_pa     (sysmap_pa),
    .req           (req_if.former)
  );

  ifetch_bus_fsm x_bus_fsm (
    .ifetch_cpuclk   (ifetch_cpuclk),
    .cpurst_b        (cpurst_b),
    .req             (req_if.fsm),
    .rsp             (rsp_if.fsm),
    .bus_grant       (bus_grant),
    .bus_trans_cmplt (bus_trans_cmplt),
    .bus_acc_err     (bus_acc_err),
    .bus_rdata       (bus_rdata),
    .fetch_abort     (fetch_abort),
    .bus_req         (bus_req),
    .bus_addr        (bus_addr),
    .bus_prot        (bus_prot),
    .bus_acc_deny    (bus_acc_deny)
  );

  ifetch_inst_out x_inst_out (
    .rsp          (rsp_if.out),
    .dbgon        (dbgon),
    .lockup_mask  (lockup_mask),
    .lpmd_req     (lpmd_req),
    .srst_req     (srst_req),
    .lockup_req   (lockup_req),
    .inst_vld     (inst_vld),
    .inst         (inst),
    .inst_acc_err (inst_acc_err),
    .inst_unalign (inst_unalign),
    .fetch_idle   (fetch_idle),
    .lpmd_ack     (lpmd_ack),
    .srst_ack     (srst_ack),
    .lockup_ack   (lockup_ack)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the fetch unit testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_ifetch -o sim_ifetch \
  && ./obj_dir/sim_ifetch 2>&1 | tee sim.log \
  || { echo "build or simulation run failed"; exit 1; }

grep -q "STATUS: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb_clkgen.sv ====
//----------------------------------------------------------------------------
// testbench clock and reset for the fetch unit
//----------------------------------------------------------------------------

module tb_clkgen (
  output logic ifetch_cpuclk,
  output logic cpurst_b
);

  // period of 4
  initial
  begin
    ifetch_cpuclk = 1'b0;
    forever #2 ifetch_cpuclk = ~ifetch_cpuclk;
  end

  // reset held for three rising edges
  initial
  begin
    cpurst_b = 1'b0;
    repeat (3) @(posedge ifetch_cpuclk);
    #1 cpurst_b = 1'b1;
  end

endmodule

// ==== tb_ifetch.sv ====
//----------------------------------------------------------------------------
// testbench for the fetch unit with bus slave model, scoreboard and stimulus
//----------------------------------------------------------------------------

module tb_ifetch
  import ifetch_pkg::*;
();

  logic              ifetch_cpuclk;
  logic              cpurst_b;
  logic              fetch_req_vld;
  logic [addr_w-1:0] fetch_addr;
  logic              fetch_abort;
  logic              fetch_grant;
  logic [flg_w-1:0]  sysmap_flg;
  logic              mach_mode;
  logic              pmp_deny;
  logic [addr_w-1:0] sysmap_pa;
  logic              bus_req;
  logic [addr_w-1:0] bus_addr;
  logic [prot_w-1:0] bus_prot;
  logic [1:0]        bus_size;
  logic              bus_acc_deny;
  logic              bus_grant;
  logic              bus_trans_cmplt;
  logic              bus_acc_err;
  logic [data_w-1:0] bus_rdata;
  logic              dbgon;
  logic              lockup_mask;
  logic              inst_vld;
  logic [data_w-1:0] inst;
  logic              inst_acc_err;
  logic              inst_unalign;
  logic              fetch_idle;
  logic              lpmd_req;
  logic              lpmd_ack;
  logic              srst_req;
  logic              srst_ack;
  logic              lockup_req;
  logic              lockup_ack;

  // one granted bus transaction as the slave sees it
  typedef struct {
    logic [addr_w-1:0] addr;
    logic              deny;
    logic              err;
    logic              dropped;
    int                due;
  } flight_t;

  flight_t fl_q [$];
  int      seed = 32'h920f688d;
  int      cyc;
  int      gnt_wait;
  int      last_due;
  logic    gnt_rdy;
  logic    pend;
  logic    err_next;
  int      err_inst = 0;
  int      err_flag = 0;
  int      err_addr = 0;
  int      err_prot = 0;

  tb_clkgen clkgen (
    .ifetch_cpuclk (ifetch_cpuclk),
    .cpurst_b      (cpurst_b)
  );

  ifetch_top UUT (
    .ifetch_cpuclk   (ifetch_cpuclk),
    .cpurst_b        (cpurst_b),
    .fetch_req_vld   (fetch_req_vld),
    .fetch_addr      (fetch_addr),
    .fetch_abort     (fetch_abort),
    .fetch_grant     (fetch_grant),
    .sysmap_flg      (sysmap_flg),
    .mach_mode       (mach_mode),
    .pmp_deny        (pmp_deny),
    .sysmap_pa       (sysmap_pa),
    .bus_req         (bus_req),
    .bus_addr        (bus_addr),
    .bus_prot        (bus_prot),
    .bus_size        (bus_size),
    .bus_acc_deny    (bus_acc_deny),
    .bus_grant       (bus_grant),
    .bus_trans_cmplt (bus_trans_cmplt),
    .bus_acc_err     (bus_acc_err),
    .bus_rdata       (bus_rdata),
    .dbgon           (dbgon),
    .lockup_mask     (lockup_mask),
    .inst_vld        (inst_vld),
    .inst            (inst),
    .inst_acc_err    (inst_acc_err),
    .inst_unalign    (inst_unalign),
    .fetch_idle      (fetch_idle),
    .lpmd_req        (lpmd_req),
    .lpmd_ack        (lpmd_ack),
    .srst_req        (srst_req),
    .srst_ack        (srst_ack),
    .lockup_req      (lockup_req),
    .lockup_ack      (lockup_ack)
  );

  bind ifetch_bus_fsm tb_ifetch_sva bus_sva (
    .ifetch_cpuclk   (ifetch_cpuclk),
    .cpurst_b        (cpurst_b),
    .cur_st          (cur_st),
    .bus_req         (bus_req),
    .bus_trans_cmplt (bus_trans_cmplt)
  );

  //--------------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------------
  // memory content is the word address mixed with a constant
  function automatic logic [data_w-1:0] ref_word(input logic [addr_w-1:0] addr);
    return (addr >> 2) ^ 32'hc3a5_5e0f;
  endfunction

  // {cacheable, bufferable, privileged, data}
  function automatic logic [prot_w-1:0] ref_prot(input logic [flg_w-1:0] flg,
                                                 input logic mm);
    return {flg[flg_ca_bit], flg[flg_buf_bit], mm, 1'b0};
  endfunction

  function automatic logic [addr_w-1:0] next_addr(input logic half);
    logic [addr_w-1:0] a;
    a    = $random(seed);
    a[1] = half;
    a[0] = 1'b0;
    return a;
  endfunction

  //--------------------------------------------------------------------------
  // compare tasks
  //--------------------------------------------------------------------------
  task automatic check_inst(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                            input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %h expected %h", $time, what, got, exp);
      err_inst++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %b expected %b", $time, what, got, exp);
      err_flag++;
    end
  endtask

  task automatic check_addr(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp,
                            input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %h expected %h", $time, what, got, exp);
      err_addr++;
    end
  endtask

  task automatic check_prot(input logic [prot_w-1:0] got, input logic [prot_w-1:0] exp,
                            input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %b expected %b", $time, what, got, exp);
      err_prot++;
    end
  endtask

  //--------------------------------------------------------------------------
  // bus slave and scoreboard
  //--------------------------------------------------------------------------
  // the slave only grants a request that is on the bus
  assign bus_grant = gnt_rdy & bus_req;

  // samples mid cycle and drives just after the rising edge
  initial
  begin : bus_slave
    flight_t ent;
    logic    exp_idle;
    int      dly_seed;
    dly_seed        = seed;
    gnt_rdy         = 1'b0;
    bus_trans_cmplt = 1'b0;
    bus_acc_err     = 1'b0;
    bus_rdata       = '0;
    cyc             = 0;
    gnt_wait        = 0;
    last_due        = 0;
    pend            = 1'b0;
    forever
    begin
      @(negedge ifetch_cpuclk);
      // a new request only reaches the bus with fewer than two in flight
      check_flag(bus_req, (fl_q.size() < 2) && fetch_req_vld, "bus_req");
      check_flag(fetch_grant, bus_grant, "fetch_grant");
      exp_idle = (fl_q.size() == 0) && !pend;
      check_flag(fetch_idle, exp_idle, "fetch_idle");
      check_flag(lpmd_ack, lpmd_req & exp_idle, "lpmd_ack");
      check_flag(srst_ack, srst_req & exp_idle, "srst_ack");
      check_flag(lockup_ack, lockup_req & exp_idle, "lockup_ack");
      check_addr(sysmap_pa, fetch_addr, "sysmap_pa");
      if (bus_trans_cmplt && fl_q.size() != 0)
      begin
        ent = fl_q.pop_front();
        if (!ent.dropped && !dbgon && !lockup_mask)
        begin
          check_flag(inst_vld, 1'b1, "inst_vld");
          check_inst(inst, ref_word(ent.addr), "inst");
          check_flag(inst_acc_err, ent.deny | ent.err, "inst_acc_err");
          check_flag(inst_unalign, ent.addr[1], "inst_unalign");
        end
        else
          check_flag(inst_vld, 1'b0, "inst_vld of a discarded completion");
      end
      else
        check_flag(inst_vld, 1'b0, "inst_vld without completion");
      // whatever is still in flight is now stale
      if (fetch_abort)
        foreach (fl_q[i])
          fl_q[i].dropped = 1'b1;
      if (bus_req && bus_grant)
      begin
        check_addr(bus_addr, {fetch_addr[addr_w-1:2], 2'b00}, "bus_addr");
        check_prot(bus_prot, ref_prot(sysmap_flg, mach_mode), "bus_prot");
        check_flag(bus_acc_deny, pmp_deny, "bus_acc_deny");
        check_flag(bus_size == bus_size_word, 1'b1, "bus_size is word");
        ent.addr    = fetch_addr;
        ent.deny    = pmp_deny;
        ent.err     = err_next;
        ent.dropped = 1'b0;
        ent.due     = cyc + 1 + ($unsigned($random(dly_seed)) % 3);
        // in order and at most one completion per cycle
        if (ent.due <= last_due)
          ent.due = last_due + 1;
        last_due = ent.due;
        fl_q.push_back(ent);
        gnt_wait = $unsigned($random(dly_seed)) % 3;
      end
      else if (bus_req && gnt_wait > 0)
        gnt_wait--;
      pend = fetch_req_vld && !fetch_grant;
      @(posedge ifetch_cpuclk);
      #1;
      cyc++;
      gnt_rdy = (gnt_wait == 0);
      if (fl_q.size() != 0 && fl_q[0].due <= cyc)
      begin
        bus_trans_cmplt = 1'b1;
        bus_rdata       = ref_word(fl_q[0].addr);
        bus_acc_err     = fl_q[0].err;
      end
      else
      begin
        bus_trans_cmplt = 1'b0;
        bus_rdata       = '0;
        bus_acc_err     = 1'b0;
      end
    end
  end

  //--------------------------------------------------------------------------
  // stimulus helpers
  //--------------------------------------------------------------------------
  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s at time %0t", what, $time);
    $display("STATUS: FAIL");
    $finish;
  endtask

  // present one fetch and hold it until granted
  task automatic issue_fetch(input logic [addr_w-1:0] addr, input logic deny,
                             input logic err);
    int n;
    @(posedge ifetch_cpuclk);
    #1;
    fetch_req_vld = 1'b1;
    fetch_addr    = addr;
    pmp_deny      = deny;
    err_next      = err;
    sysmap_flg    = flg_w'($random(seed));
    mach_mode     = 1'($random(seed));
    n = 0;
    @(negedge ifetch_cpuclk);
    while (!fetch_grant && n < 40)
    begin
      @(negedge ifetch_cpuclk);
      n++;
    end
    if (!fetch_grant)
      stop_on_timeout("a fetch grant");
  endtask

  task automatic release_fetch();
    @(posedge ifetch_cpuclk);
    #1;
    fetch_req_vld = 1'b0;
    pmp_deny      = 1'b0;
    err_next      = 1'b0;
  endtask

  // abort in the cycle right after the last grant
  task automatic abort_fetch();
    @(posedge ifetch_cpuclk);
    #1;
    fetch_req_vld = 1'b0;
    fetch_abort   = 1'b1;
    @(posedge ifetch_cpuclk);
    #1;
    fetch_abort   = 1'b0;
  endtask

  task automatic wait_quiet();
    int n;
    n = 0;
    @(posedge ifetch_cpuclk);
    while ((fl_q.size() != 0 || pend) && n < 40)
    begin
      @(posedge ifetch_cpuclk);
      n++;
    end
    if (fl_q.size() != 0 || pend)
      stop_on_timeout("the bus to drain");
  endtask

  task automatic run_burst(input int cnt);
    repeat (cnt)
      issue_fetch(next_addr(1'($random(seed))), 1'b0, 1'b0);
    release_fetch();
    wait_quiet();
  endtask

  //--------------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------------
  initial
  begin : stimulus
    int n;
    fetch_req_vld = 1'b0;
    fetch_addr    = '0;
    fetch_abort   = 1'b0;
    sysmap_flg    = '0;
    mach_mode     = 1'b0;
    pmp_deny      = 1'b0;
    err_next      = 1'b0;
    dbgon         = 1'b0;
    lockup_mask   = 1'b0;
    lpmd_req      = 1'b0;
    srst_req      = 1'b0;
    lockup_req    = 1'b0;
    n = 0;
    while (!cpurst_b && n < 20)
    begin
      @(posedge ifetch_cpuclk);
      n++;
    end
    if (!cpurst_b)
      stop_on_timeout("reset release");

    // single fetch on the upper halfword
    issue_fetch(next_addr(1'b1), 1'b0, 1'b0);
    release_fetch();
    wait_quiet();
    // back to back with up to two in flight
    run_burst(10);
    // deny and bus error between clean neighbors
    issue_fetch(next_addr(1'b0), 1'b0, 1'b0);
    issue_fetch(next_addr(1'b1), 1'b1, 1'b0);
    issue_fetch(next_addr(1'b0), 1'b0, 1'b0);
    issue_fetch(next_addr(1'b1), 1'b0, 1'b1);
    issue_fetch(next_addr(1'b0), 1'b0, 1'b0);
    release_fetch();
    wait_quiet();
    // abort with one and then two outstanding
    repeat (4)
    begin
      issue_fetch(next_addr(1'($random(seed))), 1'b0, 1'b0);
      abort_fetch();
      wait_quiet();
      run_burst(1);
    end
    repeat (4)
    begin
      issue_fetch(next_addr(1'($random(seed))), 1'b0, 1'b0);
      issue_fetch(next_addr(1'($random(seed))), 1'b0, 1'b0);
      abort_fetch();
      wait_quiet();
      run_burst(1);
    end
    // masking with the idle requests held high
    @(posedge ifetch_cpuclk);
    #1;
    dbgon      = 1'b1;
    lpmd_req   = 1'b1;
    srst_req   = 1'b1;
    lockup_req = 1'b1;
    run_burst(3);
    @(posedge ifetch_cpuclk);
    #1;
    dbgon       = 1'b0;
    lockup_mask = 1'b1;
    run_burst(3);
    @(posedge ifetch_cpuclk);
    #1;
    lockup_mask = 1'b0;
    run_burst(4);

    n = err_inst + err_flag + err_addr + err_prot;
    $display("error counts: inst %0d flag %0d addr %0d prot %0d",
             err_inst, err_flag, err_addr, err_prot);
    if (n == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== tb_ifetch_sva.sv ====
//----------------------------------------------------------------------------
// assertions on the fetch bus state machine
//----------------------------------------------------------------------------

module tb_ifetch_sva
  import ifetch_pkg::*;
(
  input logic    ifetch_cpuclk,
  input logic    cpurst_b,
  input bus_st_t cur_st,
  input logic    bus_req,
  input logic    bus_trans_cmplt
);

  // two in flight, the bus must stay quiet
  a_no_req_when_full: assert property (
    @(posedge ifetch_cpuclk) disable iff (!cpurst_b)
    (cur_st == st_wfd1_wfd2) |-> !bus_req
  ) else $error("bus request raised with two transactions in flight");

  a_state_legal: assert property (
    @(posedge ifetch_cpuclk) disable iff (!cpurst_b)
    cur_st inside {st_idle, st_wfg1, st_wfd1, st_wfd1_wfg2, st_wfd1_wfd2}
  ) else $error("bus state outside its encoding");

  // nothing outstanding in idle, so no completion either
  a_no_cmplt_in_idle: assert property (
    @(posedge ifetch_cpuclk) disable iff (!cpurst_b)
    (cur_st == st_idle) |-> !bus_trans_cmplt
  ) else $error("bus completion seen while the state machine is idle");

endmodule
